//--- hw/tl_pkg.sv
// single-beat TileLink host port with 32-bit address and data; encodings follow the TL spec
package tl_pkg;

  // bus widths
  localparam int TL_AW  = 32;
  localparam int TL_DW  = 32;
  localparam int TL_DBW = TL_DW / 8;
  localparam int TL_SZW = 2;
  localparam int TL_AIW = 8;

  // A channel opcodes, only the ones the adapter serves
  typedef enum logic [2:0] {
    PutFullData    = 3'h0,
    PutPartialData = 3'h1,
    ArithmeticData = 3'h2,
    LogicalData    = 3'h3,
    Get            = 3'h4
  } tl_a_op_e;

  // D channel opcodes
  typedef enum logic [2:0] {
    AccessAck     = 3'h0,
    AccessAckData = 3'h1
  } tl_d_op_e;

  // a_param for ArithmeticData
  localparam logic [2:0] ARITH_MIN  = 3'h0;
  localparam logic [2:0] ARITH_MAX  = 3'h1;
  localparam logic [2:0] ARITH_MINU = 3'h2;
  localparam logic [2:0] ARITH_MAXU = 3'h3;
  localparam logic [2:0] ARITH_ADD  = 3'h4;

  // a_param for LogicalData
  localparam logic [2:0] LOGIC_XOR  = 3'h0;
  localparam logic [2:0] LOGIC_OR   = 3'h1;
  localparam logic [2:0] LOGIC_AND  = 3'h2;
  localparam logic [2:0] LOGIC_SWAP = 3'h3;

endpackage

//--- hw/mem_pkg.sv
// SRAM word equals the bus word; host addresses alias modulo 2^(SRAM_AW+2) bytes
package mem_pkg;
  import tl_pkg::*;

  // word address width of the SRAM
  localparam int SRAM_AW = 10;

  // requests in flight and buffered read words
  localparam int REQ_DEPTH = 2;
  localparam int RSP_DEPTH = 2;

  // read credit counter must hold 0..RSP_DEPTH
  localparam int CREDIT_W = $clog2(RSP_DEPTH + 1);

  // what the D channel owes the host for one accepted beat
  typedef enum logic [1:0] {
    OpWrite,
    OpRead,
    OpAtomic
  } req_op_e;

  typedef struct packed {
    req_op_e             op;
    logic [TL_SZW-1:0]   size;
    logic [TL_AIW-1:0]   source;
  } req_t;

  typedef struct packed {
    logic [TL_DW-1:0] data;
  } rsp_t;

endpackage

//--- hw/atomic_alu.sv
// full-word result only; byte lanes outside the write mask are dropped at the SRAM
`timescale 1ns/10ps
module atomic_alu import tl_pkg::*; (
  input  logic [TL_DW-1:0] old_i,
  input  logic [TL_DW-1:0] operand_i,
  input  logic             arith_i,
  input  logic [2:0]       param_i,
  output logic [TL_DW-1:0] result_o
);

  logic signed_lt, unsigned_lt;

  // operand against the stored word
  assign signed_lt   = $signed(operand_i) < $signed(old_i);
  assign unsigned_lt = operand_i < old_i;

  always_comb begin
    // reserved params leave the word unchanged
    result_o = old_i;
    if (arith_i) begin
      case (param_i)
        ARITH_MIN:  result_o = signed_lt ? operand_i : old_i;
        ARITH_MAX:  result_o = signed_lt ? old_i : operand_i;
        ARITH_MINU: result_o = unsigned_lt ? operand_i : old_i;
        ARITH_MAXU: result_o = unsigned_lt ? old_i : operand_i;
        // carry out is lost, wraps like the host ALU
        ARITH_ADD:  result_o = old_i + operand_i;
        default:    result_o = old_i;
      endcase
    end else begin
      case (param_i)
        LOGIC_XOR:  result_o = old_i ^ operand_i;
        LOGIC_OR:   result_o = old_i | operand_i;
        LOGIC_AND:  result_o = old_i & operand_i;
        // swap stores the operand, old word still goes back on D
        LOGIC_SWAP: result_o = operand_i;
        default:    result_o = old_i;
      endcase
    end
  end

endmodule

//--- hw/fifo_sync.sv
// Depth of 2 or more; no wready, so the writer must check full_o before pushing
`timescale 1ns/10ps
module fifo_sync #(
  parameter type payload_t = logic,
  parameter int  Depth     = 2
) (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     wvalid_i,
  input  payload_t wdata_i,
  output logic     full_o,
  output logic     rvalid_o,
  output payload_t rdata_o,
  input  logic     rready_i
);

  localparam int PtrW = $clog2(Depth);
  localparam int CntW = $clog2(Depth + 1);

  payload_t        mem_q [Depth];
  logic [PtrW-1:0] wptr_q, rptr_q;
  logic [CntW-1:0] cnt_q;
  logic            push, pop;

  // wrap at Depth, which need not be a power of two
  function automatic logic [PtrW-1:0] next_ptr(logic [PtrW-1:0] ptr);
    return (ptr == PtrW'(Depth - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign full_o   = cnt_q == CntW'(Depth);
  assign rvalid_o = cnt_q != '0;
  // head comes straight from storage, never from wdata_i
  assign rdata_o  = mem_q[rptr_q];
  assign push     = wvalid_i && !full_o;
  assign pop      = rready_i && rvalid_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wptr_q <= '0;
      rptr_q <= '0;
      cnt_q  <= '0;
    end else begin
      if (push) wptr_q <= next_ptr(wptr_q);
      if (pop) rptr_q <= next_ptr(rptr_q);
      if (push && !pop) cnt_q <= cnt_q + 1'b1;
      else if (pop && !push) cnt_q <= cnt_q - 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) mem_q[wptr_q] <= wdata_i;
  end

  // the writer's own gating must keep these from firing
  no_push_full_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    full_o |-> !wvalid_i);
  no_pop_empty_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !rvalid_o |-> !rready_i);

endmodule

//--- hw/tl_sram_ctrl.sv
// single-beat only; unsupported A opcodes are never accepted; a_ready_o needs a_valid_i
`timescale 1ns/10ps
module tl_sram_ctrl import tl_pkg::*, mem_pkg::*; (
  input  logic               clk_i,
  input  logic               rst_ni,
  // A channel
  input  logic               a_valid_i,
  output logic               a_ready_o,
  input  logic [2:0]         a_opcode_i,
  input  logic [2:0]         a_param_i,
  input  logic [TL_SZW-1:0]  a_size_i,
  input  logic [TL_AIW-1:0]  a_source_i,
  input  logic [TL_AW-1:0]   a_address_i,
  input  logic [TL_DBW-1:0]  a_mask_i,
  input  logic [TL_DW-1:0]   a_data_i,
  // D channel
  output logic               d_valid_o,
  input  logic               d_ready_i,
  output logic [2:0]         d_opcode_o,
  output logic [TL_SZW-1:0]  d_size_o,
  output logic [TL_AIW-1:0]  d_source_o,
  output logic [TL_DW-1:0]   d_data_o,
  // SRAM
  output logic               req_o,
  input  logic               gnt_i,
  output logic               we_o,
  output logic [SRAM_AW-1:0] addr_o,
  output logic [TL_DW-1:0]   wdata_o,
  output logic [TL_DW-1:0]   wmask_o,
  input  logic               rvalid_i,
  input  logic [TL_DW-1:0]   rdata_i,
  // request fifo
  output logic               req_wvalid_o,
  output req_t               req_wdata_o,
  input  logic               req_rvalid_i,
  input  req_t               req_rdata_i,
  input  logic               req_full_i,
  output logic               req_rready_o,
  // response fifo
  output logic               rsp_wvalid_o,
  input  logic               rsp_rvalid_i,
  input  rsp_t               rsp_rdata_i,
  output logic               rsp_rready_o,
  // atomic unit
  output logic [TL_DW-1:0]   old_data_o,
  output logic [TL_DW-1:0]   operand_o,
  output logic               op_arith_o,
  output logic [2:0]         op_param_o,
  input  logic [TL_DW-1:0]   result_i
);
  typedef enum logic [1:0] {AtmIdle, AtmWaitRd, AtmWrite} atm_state_e;
  atm_state_e atm_q;
  logic is_get, is_put, is_atomic, can_accept, a_req, a_ack, d_ack, head_is_write;
  logic [CREDIT_W-1:0] credit_q;
  logic [SRAM_AW-1:0] atm_addr_q;
  logic [TL_DBW-1:0] atm_mask_q, byte_mask;
  logic [TL_DW-1:0] old_q, operand_q;
  logic arith_q;
  logic [2:0] param_q;

  // opcode classes
  assign is_get    = a_opcode_i == Get;
  assign is_put    = (a_opcode_i == PutFullData) || (a_opcode_i == PutPartialData);
  assign is_atomic = (a_opcode_i == ArithmeticData) || (a_opcode_i == LogicalData);
  // reads and atomics each need room in the response fifo
  assign can_accept = (atm_q == AtmIdle) && !req_full_i &&
                      (is_put || ((is_get || is_atomic) && credit_q != CREDIT_W'(RSP_DEPTH)));
  assign a_req     = a_valid_i && can_accept;
  // A beat, fifo push and SRAM access happen together
  assign a_ready_o = a_req && gnt_i;
  assign a_ack     = a_ready_o;
  assign req_wvalid_o       = a_ack;
  assign req_wdata_o.op     = is_get ? OpRead : (is_atomic ? OpAtomic : OpWrite);
  assign req_wdata_o.size   = a_size_i;
  assign req_wdata_o.source = a_source_i;

  // atomic write-back owns the SRAM port until granted
  always_comb begin
    if (atm_q == AtmWrite) begin
      req_o     = 1'b1;
      we_o      = 1'b1;
      addr_o    = atm_addr_q;
      wdata_o   = result_i;
      byte_mask = atm_mask_q;
    end else begin
      // atomics start as a plain read
      req_o     = a_req;
      we_o      = is_put;
      addr_o    = a_address_i[$clog2(TL_DBW) +: SRAM_AW];
      wdata_o   = a_data_i;
      byte_mask = a_mask_i;
    end
    // byte mask to bit mask
    for (int i = 0; i < TL_DBW; i++) begin
      wmask_o[8*i +: 8] = {8{byte_mask[i]}};
    end
  end

  // credit taken at read grant, returned when its word leaves on D
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      credit_q <= '0;
      atm_q    <= AtmIdle;
    end else begin
      if (a_ack && !is_put && !rsp_rready_o) credit_q <= credit_q + 1'b1;
      else if (!(a_ack && !is_put) && rsp_rready_o) credit_q <= credit_q - 1'b1;
      case (atm_q)
        AtmIdle:   if (a_ack && is_atomic) atm_q <= AtmWaitRd;
        // one-cycle latency, so this rvalid belongs to the atomic read
        AtmWaitRd: if (rvalid_i) atm_q <= AtmWrite;
        AtmWrite:  if (gnt_i) atm_q <= AtmIdle;
        default:   atm_q <= AtmIdle;
      endcase
    end
  end

  // atomic operands, captured at the A beat and at the read return
  always_ff @(posedge clk_i) begin
    if (a_ack && is_atomic) begin
      atm_addr_q <= a_address_i[$clog2(TL_DBW) +: SRAM_AW];
      atm_mask_q <= a_mask_i;
      operand_q  <= a_data_i;
      arith_q    <= a_opcode_i == ArithmeticData;
      param_q    <= a_param_i;
    end
    if (atm_q == AtmWaitRd && rvalid_i) old_q <= rdata_i;
  end
  assign old_data_o = old_q;
  assign operand_o  = operand_q;
  assign op_arith_o = arith_q;
  assign op_param_o = param_q;

  // D from the fifo heads; writes need no data word
  assign rsp_wvalid_o  = rvalid_i;
  assign head_is_write = req_rdata_i.op == OpWrite;
  assign d_valid_o     = req_rvalid_i && (head_is_write || rsp_rvalid_i);
  assign d_opcode_o    = head_is_write ? AccessAck : AccessAckData;
  assign d_size_o      = req_rdata_i.size;
  assign d_source_o    = req_rdata_i.source;
  assign d_data_o      = head_is_write ? '0 : rsp_rdata_i.data;
  assign d_ack         = d_valid_o && d_ready_i;
  // a write pops only its record, a read pops its word too
  assign req_rready_o  = d_ack;
  assign rsp_rready_o  = d_ack && !head_is_write;

  // a read return needs a grant this block issued
  rvalid_credit_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rvalid_i |-> credit_q != '0);
  d_stable_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    d_valid_o && !d_ready_i |=> d_valid_o &&
    $stable({d_opcode_o, d_size_o, d_source_o, d_data_o}));
endmodule

//--- hw/tl_sram_adapter.sv
// no base address decode; SRAM must return rdata exactly one cycle after each granted read
`timescale 1ns/10ps
module tl_sram_adapter import tl_pkg::*, mem_pkg::*; (
  input  logic               clk_i,
  input  logic               rst_ni,
  // A channel
  input  logic               a_valid_i,
  output logic               a_ready_o,
  input  logic [2:0]         a_opcode_i,
  input  logic [2:0]         a_param_i,
  input  logic [TL_SZW-1:0]  a_size_i,
  input  logic [TL_AIW-1:0]  a_source_i,
  input  logic [TL_AW-1:0]   a_address_i,
  input  logic [TL_DBW-1:0]  a_mask_i,
  input  logic [TL_DW-1:0]   a_data_i,
  // D channel
  output logic               d_valid_o,
  input  logic               d_ready_i,
  output logic [2:0]         d_opcode_o,
  output logic [TL_SZW-1:0]  d_size_o,
  output logic [TL_AIW-1:0]  d_source_o,
  output logic [TL_DW-1:0]   d_data_o,
  // SRAM
  output logic               req_o,
  input  logic               gnt_i,
  output logic               we_o,
  output logic [SRAM_AW-1:0] addr_o,
  output logic [TL_DW-1:0]   wdata_o,
  output logic [TL_DW-1:0]   wmask_o,
  input  logic [TL_DW-1:0]   rdata_i,
  input  logic               rvalid_i
);

  // request fifo, one record per accepted A beat
  logic req_wvalid, req_rvalid, req_full, req_rready;
  req_t req_wdata, req_rdata;

  // response fifo, one word per SRAM read
  logic rsp_wvalid, rsp_rvalid, rsp_rready;
  rsp_t rsp_rdata;

  // atomic operands and result
  logic [TL_DW-1:0] old_data, operand, alu_result;
  logic             op_arith;
  logic [2:0]       op_param;

  tl_sram_ctrl u_ctrl (
    .clk_i, .rst_ni,
    .a_valid_i, .a_ready_o, .a_opcode_i, .a_param_i, .a_size_i,
    .a_source_i, .a_address_i, .a_mask_i, .a_data_i,
    .d_valid_o, .d_ready_i, .d_opcode_o, .d_size_o, .d_source_o, .d_data_o,
    .req_o, .gnt_i, .we_o, .addr_o, .wdata_o, .wmask_o, .rvalid_i, .rdata_i,
    .req_wvalid_o (req_wvalid),
    .req_wdata_o  (req_wdata),
    .req_rvalid_i (req_rvalid),
    .req_rdata_i  (req_rdata),
    .req_full_i   (req_full),
    .req_rready_o (req_rready),
    .rsp_wvalid_o (rsp_wvalid),
    .rsp_rvalid_i (rsp_rvalid),
    .rsp_rdata_i  (rsp_rdata),
    .rsp_rready_o (rsp_rready),
    .old_data_o   (old_data),
    .operand_o    (operand),
    .op_arith_o   (op_arith),
    .op_param_o   (op_param),
    .result_i     (alu_result)
  );

  fifo_sync #(.payload_t(req_t), .Depth(REQ_DEPTH)) u_req_fifo (
    .clk_i, .rst_ni,
    .wvalid_i (req_wvalid),
    .wdata_i  (req_wdata),
    .full_o   (req_full),
    .rvalid_o (req_rvalid),
    .rdata_o  (req_rdata),
    .rready_i (req_rready)
  );

  // fullness is covered by the read credits in the controller
  fifo_sync #(.payload_t(rsp_t), .Depth(RSP_DEPTH)) u_rsp_fifo (
    .clk_i, .rst_ni,
    .wvalid_i (rsp_wvalid),
    .wdata_i  (rsp_t'(rdata_i)),
    .full_o   (),
    .rvalid_o (rsp_rvalid),
    .rdata_o  (rsp_rdata),
    .rready_i (rsp_rready)
  );

  atomic_alu u_alu (
    .old_i     (old_data),
    .operand_i (operand),
    .arith_i   (op_arith),
    .param_i   (op_param),
    .result_o  (alu_result)
  );

endmodule

//--- test/sram_model.sv
// behavioral SRAM with about one grant stall in four; every granted read returns one cycle later
`timescale 1ns/10ps
module sram_model import tl_pkg::*, mem_pkg::*; (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               req_i,
  output logic               gnt_o,
  input  logic               we_i,
  input  logic [SRAM_AW-1:0] addr_i,
  input  logic [TL_DW-1:0]   wdata_i,
  input  logic [TL_DW-1:0]   wmask_i,
  output logic [TL_DW-1:0]   rdata_o,
  output logic               rvalid_o
);

  logic [TL_DW-1:0] mem_q [2**SRAM_AW];

  // preload, every word differs from its neighbours
  initial begin
    for (int i = 0; i < 2**SRAM_AW; i++) begin
      mem_q[i] = 32'h9e37_79b9 * (i + 1);
    end
  end

  // grant changes only at the rising edge, independent of req_i
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      gnt_o    <= 1'b0;
      rvalid_o <= 1'b0;
    end else begin
      gnt_o    <= ($urandom % 4) != 0;
      rvalid_o <= req_i && gnt_o && !we_i;
    end
  end

  // bit-masked write, read returns the word before any write
  always @(posedge clk_i) begin
    if (req_i && gnt_o && we_i) mem_q[addr_i] <= (mem_q[addr_i] & ~wmask_i) | (wdata_i & wmask_i);
    if (req_i && gnt_o && !we_i) rdata_o <= mem_q[addr_i];
  end

endmodule

//--- test/tb_tl_sram_adapter.sv
// fixed-seed run that stops at the first error; every A beat carries a full-word a_size of 2
`timescale 1ns/10ps
module tb_tl_sram_adapter
  import tl_pkg::*, mem_pkg::*;
();

  localparam int Seed      = 80;
  localparam int WaitLimit = 100;

  // one A beat of the stimulus table
  typedef struct packed {
    int unsigned       group;
    logic [2:0]        opcode;
    logic [2:0]        param;
    logic [TL_AW-1:0]  address;
    logic [TL_DBW-1:0] mask;
    logic [TL_DW-1:0]  data;
    logic [TL_AIW-1:0] source;
  } row_t;

  // what D owes for one accepted beat
  typedef struct packed {
    int unsigned       idx;
    logic [2:0]        opcode;
    logic [TL_AIW-1:0] source;
    logic [TL_DW-1:0]  data;
  } exp_t;

  logic clk_i, rst_ni, a_valid_i, a_ready_o, d_valid_o, d_ready_i;
  logic req_o, gnt_i, we_o, rvalid_i;
  logic [2:0] a_opcode_i, a_param_i, d_opcode_o;
  logic [TL_SZW-1:0] a_size_i, d_size_o;
  logic [TL_AIW-1:0] a_source_i, d_source_o;
  logic [TL_AW-1:0] a_address_i;
  logic [TL_DBW-1:0] a_mask_i;
  logic [TL_DW-1:0] a_data_i, d_data_o, wdata_o, wmask_o, rdata_i;
  logic [SRAM_AW-1:0] addr_o;

  row_t rows[$];
  exp_t exp_q[$];
  logic [TL_DW-1:0] ref_mem [2**SRAM_AW];
  // random d_ready only during the back-to-back reads
  logic stress_d;

  tl_sram_adapter i_tl_sram_adapter (.*);

  sram_model i_sram (
    .clk_i, .rst_ni, .req_i(req_o), .gnt_o(gnt_i), .we_i(we_o), .addr_i(addr_o),
    .wdata_i(wdata_o), .wmask_i(wmask_o), .rdata_o(rdata_i), .rvalid_o(rvalid_i)
  );

  initial begin : clock_gen
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  task automatic stop_with(string msg);
    $display("%s", msg);
    $display("Verification failed");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_equal(string name, logic [TL_DW-1:0] expected,
                             logic [TL_DW-1:0] actual);
    if (expected !== actual) begin
      stop_with($sformatf("mismatch %s: expected %h, actual %h", name, expected, actual));
    end
  endtask

  function automatic string field_name(int unsigned idx, string field);
    return $sformatf("behavior %0d row %0d %s", rows[idx].group, idx, field);
  endfunction

  // same preload as the SRAM model
  function automatic logic [TL_DW-1:0] fill_word(int unsigned idx);
    return 32'h9e37_79b9 * (idx + 1);
  endfunction

  // value an atomic leaves behind, before the byte mask
  function automatic logic [TL_DW-1:0] atomic_result(row_t r, logic [TL_DW-1:0] old);
    if (r.opcode == ArithmeticData) begin
      case (r.param)
        ARITH_MIN:  return ($signed(r.data) < $signed(old)) ? r.data : old;
        ARITH_MAX:  return ($signed(r.data) > $signed(old)) ? r.data : old;
        ARITH_MINU: return (r.data < old) ? r.data : old;
        ARITH_MAXU: return (r.data > old) ? r.data : old;
        ARITH_ADD:  return old + r.data;
        default:    return old;
      endcase
    end
    case (r.param)
      LOGIC_XOR:  return old ^ r.data;
      LOGIC_OR:   return old | r.data;
      LOGIC_AND:  return old & r.data;
      LOGIC_SWAP: return r.data;
      default:    return old;
    endcase
  endfunction

  // reference step at the A beat; word index aliases modulo the SRAM size
  task automatic predict(row_t r, int unsigned idx);
    exp_t e;
    logic [SRAM_AW-1:0] w;
    logic [TL_DW-1:0] nw;
    w        = r.address[2 +: SRAM_AW];
    e.idx    = idx;
    e.source = r.source;
    e.data   = ref_mem[w];
    e.opcode = AccessAckData;
    nw       = ref_mem[w];
    if (r.opcode == PutFullData || r.opcode == PutPartialData) begin
      e.opcode = AccessAck;
      nw       = r.data;
    end else if (r.opcode != Get) begin
      nw = atomic_result(r, ref_mem[w]);
    end
    // only bytes under the mask change
    for (int b = 0; b < TL_DBW; b++) begin
      if (r.mask[b]) ref_mem[w][8*b +: 8] = nw[8*b +: 8];
    end
    exp_q.push_back(e);
  endtask

  task automatic add_row(int unsigned group, logic [2:0] opcode, logic [2:0] param,
                         logic [TL_AW-1:0] address, logic [TL_DBW-1:0] mask,
                         logic [TL_DW-1:0] data, logic [TL_AIW-1:0] source);
    rows.push_back('{group, opcode, param, address, mask, data, source});
  endtask

  // drive at the falling edge, hold until a_ready_o shows the beat goes at the next rise
  task automatic send_row(row_t r, int unsigned idx);
    int waited;
    waited = 0;
    @(negedge clk_i);
    a_valid_i   = 1'b1;
    a_opcode_i  = r.opcode;
    a_param_i   = r.param;
    a_address_i = r.address;
    a_mask_i    = r.mask;
    a_data_i    = r.data;
    a_source_i  = r.source;
    #1;
    // d_ready picks this up at the next falling edge
    stress_d    = r.group == 5;
    while (!a_ready_o) begin
      waited++;
      if (waited > WaitLimit) stop_with($sformatf("timeout: row %0d was never accepted", idx));
      @(negedge clk_i);
      #1;
    end
    predict(r, idx);
  endtask

  // D side, responses must come back in issue order
  initial begin : d_monitor
    exp_t e;
    d_ready_i = 1'b0;
    forever begin
      @(negedge clk_i);
      d_ready_i = stress_d ? 1'($urandom % 2) : 1'b1;
      #1;
      if (rst_ni && d_valid_o && d_ready_i) begin
        if (exp_q.size() == 0) stop_with("D channel returned a response nobody asked for");
        e = exp_q.pop_front();
        check_equal(field_name(e.idx, "d_opcode"), e.opcode, d_opcode_o);
        check_equal(field_name(e.idx, "d_source"), e.source, d_source_o);
        check_equal(field_name(e.idx, "d_size"), 2, d_size_o);
        if (e.opcode == AccessAckData) check_equal(field_name(e.idx, "d_data"), e.data, d_data_o);
      end
    end
  end

  initial begin : stimulus
    int waited;
    void'($urandom(Seed));
    rst_ni      = 1'b0;
    stress_d    = 1'b0;
    a_valid_i   = 1'b0;
    a_opcode_i  = Get;
    a_param_i   = '0;
    a_size_i    = 2'd2;
    a_source_i  = '0;
    a_address_i = '0;
    a_mask_i    = '0;
    a_data_i    = '0;
    for (int i = 0; i < 2**SRAM_AW; i++) begin
      ref_mem[i] = fill_word(i);
    end
    // full write then read back
    add_row(1, PutFullData, 3'd0, 32'h0000_0100, 4'hf, 32'h1122_3344, 8'h01);
    add_row(1, Get, 3'd0, 32'h0000_0100, 4'hf, 32'h0, 8'h02);
    // partial writes touch bytes 0 and 2, then byte 3
    add_row(2, PutPartialData, 3'd0, 32'h0000_0100, 4'b0101, 32'haabb_ccdd, 8'h03);
    add_row(2, PutPartialData, 3'd0, 32'h0000_0100, 4'b1000, 32'hee00_0000, 8'h04);
    add_row(2, Get, 3'd0, 32'h0000_0100, 4'hf, 32'h0, 8'h05);
    // chained, so each atomic returns the previous result
    // MIN and MAXU see 0x8000_0010, where signed and unsigned order disagree
    add_row(3, PutFullData, 3'd0, 32'h0000_0200, 4'hf, 32'h0000_0005, 8'h10);
    add_row(3, ArithmeticData, ARITH_ADD, 32'h0000_0200, 4'hf, 32'h0000_0003, 8'h11);
    add_row(3, ArithmeticData, ARITH_MIN, 32'h0000_0200, 4'hf, 32'h8000_0010, 8'h12);
    add_row(3, ArithmeticData, ARITH_MAXU, 32'h0000_0200, 4'hf, 32'h0000_0007, 8'h13);
    add_row(3, Get, 3'd0, 32'h0000_0200, 4'hf, 32'h0, 8'h14);
    // logical chain
    add_row(4, PutFullData, 3'd0, 32'h0000_0300, 4'hf, 32'hf0f0_1234, 8'h20);
    add_row(4, LogicalData, LOGIC_XOR, 32'h0000_0300, 4'hf, 32'h0ff0_00ff, 8'h21);
    add_row(4, LogicalData, LOGIC_OR, 32'h0000_0300, 4'hf, 32'h0000_ff00, 8'h22);
    add_row(4, LogicalData, LOGIC_AND, 32'h0000_0300, 4'hf, 32'hffff_0f0f, 8'h23);
    add_row(4, LogicalData, LOGIC_SWAP, 32'h0000_0300, 4'hf, 32'hcafe_babe, 8'h24);
    add_row(4, Get, 3'd0, 32'h0000_0300, 4'hf, 32'h0, 8'h25);
    // back-to-back reads of preloaded words
    for (int k = 0; k < 10; k++) begin
      add_row(5, Get, 3'd0, 32'h0000_0400 + 4 * k, 4'hf, 32'h0, TL_AIW'(8'h40 + k));
    end
    // 0x8000_5010 lands on the same word as 0x010
    add_row(6, PutFullData, 3'd0, 32'h8000_5010, 4'hf, 32'h600d_f00d, 8'h60);
    add_row(6, Get, 3'd0, 32'h0000_0010, 4'hf, 32'h0, 8'h61);
    repeat (8) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    foreach (rows[i]) begin
      send_row(rows[i], i);
    end
    @(negedge clk_i);
    a_valid_i = 1'b0;
    waited    = 0;
    while (exp_q.size() != 0) begin
      waited++;
      if (waited > WaitLimit) stop_with("timeout: D responses still missing after the last A beat");
      @(negedge clk_i);
    end
    $display("Verification passed");
    $finish;
  end

endmodule

//--- sources.f
hw/tl_pkg.sv
hw/mem_pkg.sv
hw/atomic_alu.sv
hw/fifo_sync.sv
hw/tl_sram_ctrl.sv
hw/tl_sram_adapter.sv
test/sram_model.sv
test/tb_tl_sram_adapter.sv

//--- Makefile
SIM := obj_dir/Vtb_tl_sram_adapter

.PHONY: all run clean

all: run

$(SIM): sources.f $(shell cat sources.f)
	verilator --binary --timing --assert -Wno-fatal -f sources.f --top-module tb_tl_sram_adapter

run: $(SIM)
	$(SIM) | tee sim.log
	grep -q "Verification passed" sim.log

clean:
	rm -rf obj_dir sim.log
